// File: sim.f
+incdir+tb
logic/fpu_pkg.sv
logic/operand_forward.sv
logic/cmp_decode.sv
logic/fp_compare.sv
logic/fp_except.sv
logic/fpu_cmp_unit.sv
tb/tb_fpu_cmp_unit.sv

// File: run.sh
#!/bin/sh
# build and run the compare unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_fpu_cmp_unit -o sim_tb || exit 1

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qF "*** PASSED ***" && exit 0 || exit 1

// File: tb/cmp_model.svh
// reference model for the compare unit
// operand selection, ordering by a monotonic key, exception flags and
// the retire code priority
`ifndef CMP_MODEL_SVH
`define CMP_MODEL_SVH

function automatic fpu_pkg::fp_word_t pick_operand(input fpu_pkg::operand_src_t src,
    input fpu_pkg::fp_word_t regv, input fpu_pkg::fp_word_t [NUM_FWD-1:0] bus);
  if (src.fwd_en) return bus[src.fwd_idx];
  return regv;
endfunction

// fields: {nan, snan, denorm, sign}
function automatic logic [3:0] field_info(input fpu_pkg::fp_word_t w, input logic sng);
  logic [10:0] e;
  logic [51:0] f;
  logic        s;
  logic        is_nan;
  if (sng) begin
    s = w[31];
    e = {3'd0, w[30:23]};
    f = {29'd0, w[22:0]};
    is_nan = (e == 11'h0ff) && (f != 0);
    return {is_nan, is_nan && !w[22], (e == 0) && (f != 0), s};
  end
  s = w[63];
  e = w[62:52];
  f = w[51:0];
  is_nan = (e == 11'h7ff) && (f != 0);
  return {is_nan, is_nan && !w[51], (e == 0) && (f != 0), s};
endfunction

// unsigned key that grows with the real value, both zeros map to the middle
function automatic logic [63:0] order_key(input fpu_pkg::fp_word_t w, input logic sng);
  logic [63:0] mag;
  logic        s;
  mag = sng ? {33'd0, w[30:0]} : {1'b0, w[62:0]};
  s   = sng ? w[31] : w[63];
  if (s) return 64'h8000_0000_0000_0000 - mag;
  return 64'h8000_0000_0000_0000 + mag;
endfunction

function automatic fpu_pkg::cmp_flags_t model_flags(input fpu_pkg::fp_word_t a,
    input fpu_pkg::fp_word_t b, input logic sng, input fpu_pkg::cmp_op_t op);
  fpu_pkg::cmp_flags_t f;
  logic [63:0]         ka;
  logic [63:0]         kb;
  logic [3:0]          ia;
  logic [3:0]          ib;
  f  = '0;
  ka = order_key(a, sng);
  kb = order_key(b, sng);
  ia = field_info(a, sng);
  ib = field_info(b, sng);
  if (ia[3] || ib[3]) f.unord = 1'b1;
  else if (ka < kb) f.lt = 1'b1;
  else if (ka > kb) f.gt = 1'b1;
  else f.eq = 1'b1;
  case (op)
    fpu_pkg::CMP_EQ_Q:    f.result = f.eq;
    fpu_pkg::CMP_LT_S:    f.result = f.lt;
    fpu_pkg::CMP_LE_S:    f.result = f.lt || f.eq;
    fpu_pkg::CMP_UNORD_Q: f.result = f.unord;
    fpu_pkg::CMP_NEQ_Q:   f.result = !f.eq;
    fpu_pkg::CMP_ORD_Q:   f.result = !f.unord;
    default:              f.result = 1'b0;
  endcase
  return f;
endfunction

function automatic fpu_pkg::exc_flags_t model_raised(input fpu_pkg::fp_word_t a,
    input fpu_pkg::fp_word_t b, input logic sng, input fpu_pkg::cmp_op_t op);
  fpu_pkg::exc_flags_t r;
  logic [3:0]          ia;
  logic [3:0]          ib;
  logic                sig_op;
  ia     = field_info(a, sng);
  ib     = field_info(b, sng);
  sig_op = (op == fpu_pkg::CMP_LT_S) || (op == fpu_pkg::CMP_LE_S);
  r.invalid  = ia[2] || ib[2] || (sig_op && (ia[3] || ib[3]));
  r.denormal = ia[1] || ib[1];
  return r;
endfunction

function automatic fpu_pkg::exc_code_t model_code(input fpu_pkg::exc_flags_t r,
    input fpu_pkg::exc_flags_t en);
  if (r.invalid && en.invalid) return 4'd1;
  if (r.denormal && en.denormal) return 4'd2;
  return 4'd0;
endfunction

`endif

// File: tb/tb_fpu_cmp_unit.sv
// testbench for the pipelined compare unit
// random back-to-back commands with special operands, checked against
// the reference model through in-order scoreboard queues
`timescale 1ns/1ps

module tb_fpu_cmp_unit;

  localparam int NUM_FWD = fpu_pkg::DEFAULT_NUM_FWD;
  localparam int NUM_CMDS = 600;

  `include "cmp_model.svh"

  logic                            clk;
  logic                            rst;
  logic                            issue;
  fpu_pkg::issue_cmd_t             cmd;
  fpu_pkg::fp_word_t               reg_a;
  fpu_pkg::fp_word_t               reg_b;
  fpu_pkg::fp_word_t [NUM_FWD-1:0] fwd_bus;
  fpu_pkg::exc_flags_t             exc_enable;
  logic                            res_valid;
  fpu_pkg::cmp_flags_t             res_flags;
  logic                            ret_valid;
  fpu_pkg::exc_code_t              ret_code;
  fpu_pkg::exc_flags_t             raised;

  integer seed = 32'hd21e;
  int errors = 0;
  int checks = 0;
  int cyc = 0;
  int since_rst = 0;
  int rets_seen = 0;
  int rets_expected = 0;
  fpu_pkg::cmp_flags_t flags_q[$];
  fpu_pkg::exc_flags_t raised_q[$];
  int                  res_cyc_q[$];
  fpu_pkg::exc_code_t  code_q[$];
  int                  ret_cyc_q[$];

  fpu_cmp_unit #(.NUM_FWD(NUM_FWD)) i_fpu_cmp_unit (
    .clk(clk), .rst(rst), .issue(issue), .cmd(cmd), .reg_a(reg_a), .reg_b(reg_b),
    .fwd_bus(fwd_bus), .exc_enable(exc_enable), .res_valid(res_valid),
    .res_flags(res_flags), .ret_valid(ret_valid), .ret_code(ret_code), .raised(raised)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic fpu_pkg::fp_word_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // roughly 30% special values, rest random bits
  function automatic fpu_pkg::fp_word_t pick_value(input logic sng);
    logic [31:0] r;
    logic [31:0] hi;
    r  = $random(seed);
    hi = $random(seed);
    if (r[6:0] >= 7'd38) return rand_word();
    case (r[9:7] % 3'd7)
      3'd0: return sng ? {hi, 32'h7fc0_0001} : 64'h7ff8_0000_0000_0001;
      3'd1: return sng ? {hi, 32'h7f80_0005} : 64'h7ff0_0000_0000_0005;
      3'd2: return sng ? {hi, 32'h0000_0000} : 64'h0000_0000_0000_0000;
      3'd3: return sng ? {hi, 32'h8000_0000} : 64'h8000_0000_0000_0000;
      3'd4: return sng ? {hi, 32'h0000_0123} : 64'h0000_0000_0000_0123;
      3'd5: return sng ? {hi, 32'h807f_ffff} : 64'h800f_ffff_ffff_ffff;
      default: return sng ? {hi, 32'h7f80_0000} : 64'h7ff0_0000_0000_0000;
    endcase
  endfunction

  // stimulus
  initial begin
    fpu_pkg::issue_cmd_t             c;
    fpu_pkg::fp_word_t [NUM_FWD-1:0] bus;
    logic [31:0]                     r;
    rst        <= 1'b1;
    issue      <= 1'b0;
    cmd        <= '0;
    reg_a      <= '0;
    reg_b      <= '0;
    fwd_bus    <= '0;
    exc_enable <= '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < NUM_CMDS; i++) begin
      @(posedge clk);
      r = $random(seed);
      c.op          = fpu_pkg::cmp_op_t'(r[7:0] % 8'd6);
      c.sng         = r[8];
      c.src_a       = {r[9], r[11:10]};
      c.src_b       = {r[12], r[14:13]};
      for (int k = 0; k < NUM_FWD; k++) bus[k] = pick_value(c.sng);
      issue      <= (r[17:16] != 2'd0);
      cmd        <= c;
      reg_a      <= pick_value(c.sng);
      // equal pairs on the register path now and then
      reg_b      <= r[20:18] == 3'd0 ? bus[0] : pick_value(c.sng);
      fwd_bus    <= bus;
      exc_enable <= r[22:21];
    end
    @(posedge clk);
    issue <= 1'b0;
    while (flags_q.size() != 0 || code_q.size() != 0) @(posedge clk);
    // one more stage for any stray retire strobe
    repeat (2) @(posedge clk);
    checks++;
    assert (rets_seen == rets_expected) else begin
      errors++;
      $display("[FAIL] ret_valid count got %h exp %h", rets_seen, rets_expected);
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // model and checks on the falling edge where everything is settled
  always @(negedge clk) begin
    fpu_pkg::fp_word_t   a;
    fpu_pkg::fp_word_t   b;
    fpu_pkg::exc_flags_t r;
    cyc++;
    since_rst = rst ? 0 : since_rst + 1;
    // strobes are only defined once the first clock edge has seen reset
    if ($time > 0 && (rst || since_rst <= 2)) begin
      checks++;
      assert (!res_valid && !ret_valid) else begin
        errors++;
        $display("valid strobe high during or right after reset");
      end
    end
    if (issue && !rst) begin
      a = pick_operand(cmd.src_a, reg_a, fwd_bus);
      b = pick_operand(cmd.src_b, reg_b, fwd_bus);
      r = model_raised(a, b, cmd.sng, cmd.op);
      flags_q.push_back(model_flags(a, b, cmd.sng, cmd.op));
      raised_q.push_back(r);
      res_cyc_q.push_back(cyc);
      if (model_code(r, exc_enable) != 4'd0) begin
        rets_expected++;
        code_q.push_back(model_code(r, exc_enable));
        ret_cyc_q.push_back(cyc);
      end
    end
    if (res_valid) begin
      checks++;
      assert (flags_q.size() != 0) else begin
        errors++;
        $display("res_valid with no command outstanding");
      end
      if (flags_q.size() != 0) begin
        assert (res_flags == flags_q[0]) else begin
          errors++;
          $display("[FAIL] res_flags got %h exp %h", res_flags, flags_q[0]);
        end
        assert (raised == raised_q[0]) else begin
          errors++;
          $display("[FAIL] raised got %h exp %h", raised, raised_q[0]);
        end
        assert (cyc - res_cyc_q[0] == 3) else begin
          errors++;
          $display("[FAIL] res_valid latency got %h exp %h", cyc - res_cyc_q[0], 3);
        end
        void'(flags_q.pop_front());
        void'(raised_q.pop_front());
        void'(res_cyc_q.pop_front());
      end
    end
    if (ret_valid) begin
      rets_seen++;
      checks++;
      assert (code_q.size() != 0) else begin
        errors++;
        $display("ret_valid with no enabled exception expected");
      end
      if (code_q.size() != 0) begin
        assert (ret_code == code_q[0] && cyc - ret_cyc_q[0] == 4) else begin
          errors++;
          $display("[FAIL] ret_code got %h exp %h, latency %h", ret_code, code_q[0],
                   cyc - ret_cyc_q[0]);
        end
        void'(code_q.pop_front());
        void'(ret_cyc_q.pop_front());
      end
    end
  end

  // watchdog
  initial begin
    #((NUM_CMDS * 2 + 50) * 40);
    $display("timeout, results still outstanding when the watchdog expired");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: logic/fpu_cmp_unit.sv
// pipelined floating-point compare unit
// forward, decode, compare and exception stages, results three cycles
// and retire codes four cycles after issue
`timescale 1ns/1ps

module fpu_cmp_unit #(
  parameter int NUM_FWD = fpu_pkg::DEFAULT_NUM_FWD
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            issue,
  input  fpu_pkg::issue_cmd_t             cmd,
  input  fpu_pkg::fp_word_t               reg_a,
  input  fpu_pkg::fp_word_t               reg_b,
  input  fpu_pkg::fp_word_t [NUM_FWD-1:0] fwd_bus,
  input  fpu_pkg::exc_flags_t             exc_enable,
  output logic                            res_valid,
  output fpu_pkg::cmp_flags_t             res_flags,
  output logic                            ret_valid,
  output fpu_pkg::exc_code_t              ret_code,
  output fpu_pkg::exc_flags_t             raised
);

  logic                fwd_valid;
  fpu_pkg::issue_cmd_t fwd_cmd;
  fpu_pkg::fp_word_t   op_a;
  fpu_pkg::fp_word_t   op_b;
  fpu_pkg::exc_flags_t fwd_enable;
  logic                dec_valid;
  fpu_pkg::cmp_ctrl_t  ctrl;
  fpu_pkg::fp_word_t   dec_a;
  fpu_pkg::fp_word_t   dec_b;
  fpu_pkg::exc_flags_t dec_enable;
  fpu_pkg::exc_flags_t res_enable;

  operand_forward #(.NUM_FWD(NUM_FWD)) i_operand_forward (
    .clk(clk), .rst(rst), .issue(issue), .cmd(cmd),
    .reg_a(reg_a), .reg_b(reg_b), .fwd_bus(fwd_bus), .exc_enable(exc_enable),
    .fwd_valid(fwd_valid), .fwd_cmd(fwd_cmd), .op_a(op_a), .op_b(op_b),
    .fwd_enable(fwd_enable)
  );

  cmp_decode i_cmp_decode (
    .clk(clk), .rst(rst), .fwd_valid(fwd_valid), .fwd_cmd(fwd_cmd),
    .op_a(op_a), .op_b(op_b), .fwd_enable(fwd_enable),
    .dec_valid(dec_valid), .ctrl(ctrl), .dec_a(dec_a), .dec_b(dec_b),
    .dec_enable(dec_enable)
  );

  fp_compare i_fp_compare (
    .clk(clk), .rst(rst), .dec_valid(dec_valid), .ctrl(ctrl),
    .dec_a(dec_a), .dec_b(dec_b), .dec_enable(dec_enable),
    .res_valid(res_valid), .res_flags(res_flags), .raised(raised),
    .res_enable(res_enable)
  );

  fp_except i_fp_except (
    .clk(clk), .rst(rst), .res_valid(res_valid), .raised(raised),
    .res_enable(res_enable), .ret_valid(ret_valid), .ret_code(ret_code)
  );

endmodule

// File: logic/fp_except.sv
// compare exception encoder
// masks raised flags with the enables carried along the pipe and
// registers a retire code, invalid ahead of denormal
`timescale 1ns/1ps

module fp_except (
  input  logic                clk,
  input  logic                rst,
  input  logic                res_valid,
  input  fpu_pkg::exc_flags_t raised,
  input  fpu_pkg::exc_flags_t res_enable,
  output logic                ret_valid,
  output fpu_pkg::exc_code_t  ret_code
);

  fpu_pkg::exc_flags_t masked;
  fpu_pkg::exc_code_t  code_d;

  assign masked = raised & res_enable;

  always_comb begin
    if (masked.invalid) begin
      code_d = fpu_pkg::EXC_INVALID;
    end else if (masked.denormal) begin
      code_d = fpu_pkg::EXC_DENORM;
    end else begin
      code_d = fpu_pkg::EXC_NONE;
    end
  end

  // retire only when some enabled flag fired
  always_ff @(posedge clk) begin
    if (rst) begin
      ret_valid <= 1'b0;
    end else begin
      ret_valid <= res_valid & (|masked);
    end
  end

  always_ff @(posedge clk) begin
    ret_code <= code_d;
  end

  a_code_nonzero: assert property (
    @(posedge clk) disable iff (rst)
    ret_valid |-> ret_code != fpu_pkg::EXC_NONE
  );

endmodule

// File: logic/fp_compare.sv
// floating-point compare stage
// classifies both operands as binary64 or binary32, orders them by sign
// and magnitude and reports the relation and the raised exceptions
`timescale 1ns/1ps

module fp_compare (
  input  logic                clk,
  input  logic                rst,
  input  logic                dec_valid,
  input  fpu_pkg::cmp_ctrl_t  ctrl,
  input  fpu_pkg::fp_word_t   dec_a,
  input  fpu_pkg::fp_word_t   dec_b,
  input  fpu_pkg::exc_flags_t dec_enable,
  output logic                res_valid,
  output fpu_pkg::cmp_flags_t res_flags,
  output fpu_pkg::exc_flags_t raised,
  output fpu_pkg::exc_flags_t res_enable
);

  // one operand seen through the selected field layout
  typedef struct packed {
    logic        sign;
    logic [62:0] mag;
    logic        nan;
    logic        snan;
    logic        zero;
    logic        denorm;
  } opnd_class_t;

  function automatic opnd_class_t classify(input fpu_pkg::fp_word_t w, input logic sng);
    opnd_class_t c;
    logic        exp_ones;
    logic        exp_zero;
    logic        frac_zero;
    logic        quiet;
    if (sng) begin
      // binary32 in the low word, upper half ignored
      c.sign    = w[31];
      c.mag     = {32'd0, w[30:0]};
      exp_ones  = &w[30:23];
      exp_zero  = ~|w[30:23];
      frac_zero = ~|w[22:0];
      quiet     = w[22];
    end else begin
      c.sign    = w[63];
      c.mag     = w[62:0];
      exp_ones  = &w[62:52];
      exp_zero  = ~|w[62:52];
      frac_zero = ~|w[51:0];
      quiet     = w[51];
    end
    c.nan    = exp_ones & ~frac_zero;
    c.snan   = c.nan & ~quiet;
    c.zero   = exp_zero & frac_zero;
    c.denorm = exp_zero & ~frac_zero;
    return c;
  endfunction

  opnd_class_t         a_c;
  opnd_class_t         b_c;
  logic                mag_lt;
  logic                mag_eq;
  fpu_pkg::cmp_flags_t flags_d;
  fpu_pkg::exc_flags_t raised_d;

  always_comb begin
    a_c     = classify(dec_a, ctrl.sng);
    b_c     = classify(dec_b, ctrl.sng);
    mag_lt  = a_c.mag < b_c.mag;
    mag_eq  = a_c.mag == b_c.mag;
    flags_d = '0;
    if (a_c.nan || b_c.nan) begin
      flags_d.unord = 1'b1;
    end else if ((a_c.zero && b_c.zero) || (a_c.sign == b_c.sign && mag_eq)) begin
      // +0 and -0 are equal
      flags_d.eq = 1'b1;
    end else if (a_c.sign != b_c.sign) begin
      flags_d.lt = a_c.sign;
      flags_d.gt = b_c.sign;
    end else if (a_c.sign) begin
      // both negative, larger magnitude is smaller
      flags_d.lt = ~mag_lt;
      flags_d.gt = mag_lt;
    end else begin
      flags_d.lt = mag_lt;
      flags_d.gt = ~mag_lt;
    end
    flags_d.result = |(ctrl.want & {flags_d.unord, flags_d.lt, flags_d.eq, flags_d.gt});

    raised_d.invalid  = a_c.snan | b_c.snan | (ctrl.signaling & flags_d.unord);
    raised_d.denormal = a_c.denorm | b_c.denorm;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    res_flags  <= flags_d;
    raised     <= raised_d;
    res_enable <= dec_enable;
  end

  // a decoded compare always resolves to exactly one relation
  a_one_relation: assert property (
    @(posedge clk) disable iff (rst)
    dec_valid |=> $onehot({res_flags.unord, res_flags.lt, res_flags.eq, res_flags.gt})
  );

endmodule

// File: logic/cmp_decode.sv
// compare decode stage
// turns the op code into a relation mask and a signaling bit, and
// carries the operands and exception enables one stage further
`timescale 1ns/1ps

module cmp_decode (
  input  logic                clk,
  input  logic                rst,
  input  logic                fwd_valid,
  input  fpu_pkg::issue_cmd_t fwd_cmd,
  input  fpu_pkg::fp_word_t   op_a,
  input  fpu_pkg::fp_word_t   op_b,
  input  fpu_pkg::exc_flags_t fwd_enable,
  output logic                dec_valid,
  output fpu_pkg::cmp_ctrl_t  ctrl,
  output fpu_pkg::fp_word_t   dec_a,
  output fpu_pkg::fp_word_t   dec_b,
  output fpu_pkg::exc_flags_t dec_enable
);

  fpu_pkg::cmp_ctrl_t ctrl_d;

  always_comb begin
    ctrl_d.sng       = fwd_cmd.sng;
    ctrl_d.signaling = 1'b0;
    ctrl_d.want      = '0;
    case (fwd_cmd.op)
      fpu_pkg::CMP_EQ_Q: begin
        ctrl_d.want = fpu_pkg::REL_EQ;
      end
      fpu_pkg::CMP_LT_S: begin
        ctrl_d.want      = fpu_pkg::REL_LT;
        ctrl_d.signaling = 1'b1;
      end
      fpu_pkg::CMP_LE_S: begin
        ctrl_d.want      = fpu_pkg::REL_LT | fpu_pkg::REL_EQ;
        ctrl_d.signaling = 1'b1;
      end
      fpu_pkg::CMP_UNORD_Q: begin
        ctrl_d.want = fpu_pkg::REL_UNORD;
      end
      // not equal includes the unordered case
      fpu_pkg::CMP_NEQ_Q: begin
        ctrl_d.want = fpu_pkg::REL_UNORD | fpu_pkg::REL_LT | fpu_pkg::REL_GT;
      end
      fpu_pkg::CMP_ORD_Q: begin
        ctrl_d.want = fpu_pkg::REL_LT | fpu_pkg::REL_EQ | fpu_pkg::REL_GT;
      end
      // spare encodings select no relation
      default: ctrl_d.want = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= fwd_valid;
    end
  end

  always_ff @(posedge clk) begin
    ctrl       <= ctrl_d;
    dec_a      <= op_a;
    dec_b      <= op_b;
    dec_enable <= fwd_enable;
  end

endmodule

// File: logic/operand_forward.sv
// operand forward stage
// picks each compare operand from the register file value or a live
// result bus and registers it with the command and exception enables
`timescale 1ns/1ps

module operand_forward #(
  parameter int NUM_FWD = fpu_pkg::DEFAULT_NUM_FWD
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  issue,
  input  fpu_pkg::issue_cmd_t                   cmd,
  input  fpu_pkg::fp_word_t                     reg_a,
  input  fpu_pkg::fp_word_t                     reg_b,
  input  fpu_pkg::fp_word_t [NUM_FWD-1:0]       fwd_bus,
  input  fpu_pkg::exc_flags_t                   exc_enable,
  output logic                                  fwd_valid,
  output fpu_pkg::issue_cmd_t                   fwd_cmd,
  output fpu_pkg::fp_word_t                     op_a,
  output fpu_pkg::fp_word_t                     op_b,
  output fpu_pkg::exc_flags_t                   fwd_enable
);

  fpu_pkg::fp_word_t sel_a;
  fpu_pkg::fp_word_t sel_b;

  // live bus only, no registered copies of the result buses
  assign sel_a = cmd.src_a.fwd_en ? fwd_bus[cmd.src_a.fwd_idx] : reg_a;
  assign sel_b = cmd.src_b.fwd_en ? fwd_bus[cmd.src_b.fwd_idx] : reg_b;

  always_ff @(posedge clk) begin
    if (rst) begin
      fwd_valid <= 1'b0;
    end else begin
      fwd_valid <= issue;
    end
  end

  always_ff @(posedge clk) begin
    fwd_cmd    <= cmd;
    op_a       <= sel_a;
    op_b       <= sel_b;
    fwd_enable <= exc_enable;
  end

  // a forwarded operand must name a bus that exists on this unit
  a_fwd_idx_range: assert property (
    @(posedge clk) disable iff (rst)
    issue |-> (!cmd.src_a.fwd_en || int'(cmd.src_a.fwd_idx) < NUM_FWD) &&
              (!cmd.src_b.fwd_en || int'(cmd.src_b.fwd_idx) < NUM_FWD)
  );

endmodule

// File: logic/fpu_pkg.sv
// fpu compare unit shared definitions
// operand words, forwarding selects, compare op codes, pipeline payloads
// and the exception retire codes
package fpu_pkg;

  // operand or result-bus word, binary64 or binary32 in the low half
  typedef logic [63:0] fp_word_t;

  // index of a forwarding result bus
  typedef logic [1:0] fwd_idx_t;

  // relation mask, bit order unordered, less, equal, greater
  typedef logic [3:0] rel_mask_t;

  // retire code reported for an enabled exception
  typedef logic [3:0] exc_code_t;

  localparam int DEFAULT_NUM_FWD = 4;

  localparam rel_mask_t REL_UNORD = 4'b1000;
  localparam rel_mask_t REL_LT    = 4'b0100;
  localparam rel_mask_t REL_EQ    = 4'b0010;
  localparam rel_mask_t REL_GT    = 4'b0001;

  localparam exc_code_t EXC_NONE    = 4'd0;
  localparam exc_code_t EXC_INVALID = 4'd1;
  localparam exc_code_t EXC_DENORM  = 4'd2;

  // _Q ops are quiet, _S ops trap on any NaN
  typedef enum logic [2:0] {
    CMP_EQ_Q    = 3'd0,
    CMP_LT_S    = 3'd1,
    CMP_LE_S    = 3'd2,
    CMP_UNORD_Q = 3'd3,
    CMP_NEQ_Q   = 3'd4,
    CMP_ORD_Q   = 3'd5
  } cmp_op_t;

  // register value is used when fwd_en is clear
  typedef struct packed {
    logic     fwd_en;
    fwd_idx_t fwd_idx;
  } operand_src_t;

  typedef struct packed {
    cmp_op_t      op;
    logic         sng;
    operand_src_t src_a;
    operand_src_t src_b;
  } issue_cmd_t;

  typedef struct packed {
    logic      sng;
    logic      signaling;
    rel_mask_t want;
  } cmp_ctrl_t;

  // result is the OR of the relations picked by want
  typedef struct packed {
    logic unord;
    logic lt;
    logic eq;
    logic gt;
    logic result;
  } cmp_flags_t;

  typedef struct packed {
    logic invalid;
    logic denormal;
  } exc_flags_t;

endpackage
